//--- all.f
hw/lc3b_types.sv
hw/cache_control.sv
hw/cache_datapath.sv
hw/l1_cache.sv
hw/mem_arbiter.sv
hw/mem_hier.sv
sim/tb_mem_model.sv
sim/tb_mem_hier.sv

//--- hw/cache_control.sv
`timescale 1ns/1ps
`default_nettype none

module cache_control import lc3b_types::*; (
    input  logic     clk,
    input  logic     i_arst_n,

    input  cpu_req_t i_cpu_req,
    input  stat_t    i_stat,
    input  logic     i_mem_resp,

    output ctrl_t    o_ctrl,
    output logic     o_cpu_resp,
    output logic     o_mem_read,
    output logic     o_mem_write
);

    typedef enum logic [1:0] {
        S_COMPARE,
        S_RESPOND,
        S_WRITEBACK,
        S_FILL
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   cpu_active;
    logic   resp_q;

    assign cpu_active = i_cpu_req.read | i_cpu_req.write;

    always_comb begin
        state_d     = state_q;
        o_ctrl      = '0;
        o_mem_read  = 1'b0;
        o_mem_write = 1'b0;

        case (state_q)
            S_COMPARE: begin
                if (cpu_active) begin
                    if (i_stat.hit) begin
                        // write hit updates the line in this cycle
                        o_ctrl.load_word = i_cpu_req.write;
                        o_ctrl.set_dirty = i_cpu_req.write;
                        state_d          = S_RESPOND;
                    end else if (i_stat.dirty) begin
                        state_d = S_WRITEBACK;  // victim must go out first
                    end else begin
                        state_d = S_FILL;
                    end
                end
            end

            // request is still held here, so nothing is touched
            S_RESPOND: begin
                state_d = S_COMPARE;
            end

            S_WRITEBACK: begin
                o_mem_write        = 1'b1;
                o_ctrl.sel_wb_addr = 1'b1;
                if (i_mem_resp) begin
                    state_d = S_FILL;
                end
            end

            S_FILL: begin
                o_mem_read = 1'b1;
                if (i_mem_resp) begin
                    o_ctrl.load_line   = 1'b1;
                    o_ctrl.clear_dirty = 1'b1;
                    state_d            = S_COMPARE;  // retry as a hit
                end
            end

            default: begin
                state_d = S_COMPARE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= S_COMPARE;
            resp_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            resp_q  <= (state_d == S_RESPOND);  // one cycle, only reached from compare
        end
    end

    assign o_cpu_resp = resp_q;

endmodule : cache_control

`default_nettype wire

//--- hw/cache_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module cache_datapath import lc3b_types::*; (
    input  logic     clk,
    input  logic     i_arst_n,

    input  cpu_req_t i_cpu_req,
    input  ctrl_t    i_ctrl,
    input  lc3b_line i_mem_rdata,

    output stat_t    o_stat,
    output lc3b_word o_rdata,
    output lc3b_word o_victim_addr,
    output lc3b_line o_victim_line
);

    // storage
    lc3b_tag             tag_arr  [NUM_SETS];
    lc3b_line            line_arr [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;

    // address fields
    lc3b_tag   req_tag;
    lc3b_index req_idx;
    logic [2:0] word_sel;
    logic [6:0] word_off;  // bit offset of the selected word

    lc3b_line cur_line;
    lc3b_tag  cur_tag;
    lc3b_word cur_word;
    lc3b_line merged_line;
    lc3b_word rdata_q;

    assign req_tag  = i_cpu_req.address[LINE_OFFSET_BITS+INDEX_BITS +: TAG_BITS];
    assign req_idx  = i_cpu_req.address[LINE_OFFSET_BITS +: INDEX_BITS];
    assign word_sel = i_cpu_req.address[LINE_OFFSET_BITS-1:1];  // bit 0 ignored
    assign word_off = {word_sel, 4'h0};

    // arrays are read combinationally
    assign cur_line = line_arr[req_idx];
    assign cur_tag  = tag_arr[req_idx];
    assign cur_word = cur_line[word_off +: 16];

    assign o_stat.hit   = valid_q[req_idx] && (cur_tag == req_tag);
    assign o_stat.dirty = valid_q[req_idx] && dirty_q[req_idx];

    // victim goes back to where it came from
    assign o_victim_addr = {cur_tag, req_idx, {LINE_OFFSET_BITS{1'b0}}};
    assign o_victim_line = cur_line;

    // byte merge of cpu write data
    always_comb begin
        merged_line = cur_line;
        if (i_cpu_req.byte_enable[0]) begin
            merged_line[word_off +: 8] = i_cpu_req.wdata[7:0];
        end
        if (i_cpu_req.byte_enable[1]) begin
            merged_line[word_off + 7'd8 +: 8] = i_cpu_req.wdata[15:8];
        end
    end

    // line and tag payload
    always_ff @(posedge clk) begin
        if (i_ctrl.load_line) begin
            line_arr[req_idx] <= i_mem_rdata;
            tag_arr[req_idx]  <= req_tag;
        end else if (i_ctrl.load_word) begin
            line_arr[req_idx] <= merged_line;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (i_ctrl.load_line) begin
                valid_q[req_idx] <= 1'b1;
            end
            if (i_ctrl.set_dirty) begin
                dirty_q[req_idx] <= 1'b1;
            end else if (i_ctrl.clear_dirty) begin
                dirty_q[req_idx] <= 1'b0;
            end
        end
    end

    // sampled every cycle, valid while resp is high
    always_ff @(posedge clk) begin
        rdata_q <= cur_word;
    end

    assign o_rdata = rdata_q;

endmodule : cache_datapath

`default_nettype wire

//--- hw/l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache import lc3b_types::*; (
    input  logic     clk,
    input  logic     i_arst_n,

    input  cpu_req_t i_cpu_req,
    output cpu_rsp_t o_cpu_rsp,

    output mem_req_t o_mem_req,
    input  mem_rsp_t i_mem_rsp
);

    ctrl_t    ctrl;
    stat_t    stat;
    lc3b_word victim_addr;
    lc3b_line victim_line;
    lc3b_word line_addr;

    cache_control control (
        .clk,
        .i_arst_n,
        .i_cpu_req,
        .i_stat      (stat),
        .i_mem_resp  (i_mem_rsp.resp),
        .o_ctrl      (ctrl),
        .o_cpu_resp  (o_cpu_rsp.resp),
        .o_mem_read  (o_mem_req.read),
        .o_mem_write (o_mem_req.write)
    );

    cache_datapath datapath (
        .clk,
        .i_arst_n,
        .i_cpu_req,
        .i_ctrl        (ctrl),
        .i_mem_rdata   (i_mem_rsp.rdata),
        .o_stat        (stat),
        .o_rdata       (o_cpu_rsp.rdata),
        .o_victim_addr (victim_addr),
        .o_victim_line (victim_line)
    );

    assign line_addr = {i_cpu_req.address[15:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

    assign o_mem_req.address = ctrl.sel_wb_addr ? victim_addr : line_addr;
    assign o_mem_req.wdata   = victim_line;  // only meaningful on write-back

endmodule : l1_cache

`default_nettype wire

//--- hw/lc3b_types.sv
`default_nettype none

package lc3b_types;

    // cache geometry
    localparam int LINE_OFFSET_BITS = 4;  // byte offset within a 16-byte line
    localparam int NUM_SETS         = 8;
    localparam int INDEX_BITS       = 3;
    localparam int TAG_BITS         = 16 - INDEX_BITS - LINE_OFFSET_BITS;

    typedef logic [15:0]           lc3b_word;
    typedef logic [1:0]            lc3b_mem_wmask;  // bit 1 high byte, bit 0 low byte
    typedef logic [127:0]          lc3b_line;
    typedef logic [TAG_BITS-1:0]   lc3b_tag;
    typedef logic [INDEX_BITS-1:0] lc3b_index;

    // core side, read or write held until resp
    typedef struct packed {
        logic          read;
        logic          write;
        lc3b_mem_wmask byte_enable;
        lc3b_word      address;
        lc3b_word      wdata;
    } cpu_req_t;

    typedef struct packed {
        logic     resp;
        lc3b_word rdata;
    } cpu_rsp_t;

    // memory side, always whole lines
    typedef struct packed {
        logic     read;
        logic     write;
        lc3b_word address;  // line aligned
        lc3b_line wdata;
    } mem_req_t;

    typedef struct packed {
        logic     resp;
        lc3b_line rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic load_line;    // fill from memory
        logic load_word;    // merge cpu write
        logic set_dirty;
        logic clear_dirty;
        logic sel_wb_addr;  // victim address onto memory port
    } ctrl_t;

    typedef struct packed {
        logic hit;
        logic dirty;
    } stat_t;

endpackage : lc3b_types

`default_nettype wire

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import lc3b_types::*; (
    input  logic     clk,
    input  logic     i_arst_n,

    // instruction cache side
    input  mem_req_t i_ireq,
    output mem_rsp_t o_irsp,

    // data cache side
    input  mem_req_t i_dreq,
    output mem_rsp_t o_drsp,

    // shared memory port
    output mem_req_t o_mem_req,
    input  mem_rsp_t i_mem_rsp
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_INSN,
        OWN_DATA
    } owner_e;

    owner_e owner_q;
    logic   ireq_active;
    logic   dreq_active;

    assign ireq_active = i_ireq.read | i_ireq.write;
    assign dreq_active = i_dreq.read | i_dreq.write;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            owner_q <= OWN_NONE;
        end else begin
            case (owner_q)
                OWN_NONE: begin
                    if (dreq_active) begin
                        owner_q <= OWN_DATA;  // data side wins a tie
                    end else if (ireq_active) begin
                        owner_q <= OWN_INSN;
                    end
                end
                default: begin
                    // release at the edge closing the resp cycle
                    if (i_mem_rsp.resp) begin
                        owner_q <= OWN_NONE;
                    end
                end
            endcase
        end
    end

    // forward the owner's request, nothing while idle
    always_comb begin
        case (owner_q)
            OWN_INSN: o_mem_req = i_ireq;
            OWN_DATA: o_mem_req = i_dreq;
            default:  o_mem_req = '0;
        endcase
    end

    assign o_irsp.resp  = i_mem_rsp.resp && (owner_q == OWN_INSN);
    assign o_drsp.resp  = i_mem_rsp.resp && (owner_q == OWN_DATA);
    assign o_irsp.rdata = i_mem_rsp.rdata;  // rdata shared, resp picks the reader
    assign o_drsp.rdata = i_mem_rsp.rdata;

endmodule : mem_arbiter

`default_nettype wire

//--- hw/mem_hier.sv
`timescale 1ns/1ps
`default_nettype none

module mem_hier import lc3b_types::*; (
    input  logic     clk,
    input  logic     i_arst_n,

    // instruction fetch port
    input  cpu_req_t i_ireq,
    output cpu_rsp_t o_irsp,

    // load/store port
    input  cpu_req_t i_dreq,
    output cpu_rsp_t o_drsp,

    // main memory
    output mem_req_t o_mem_req,
    input  mem_rsp_t i_mem_rsp
);

    // cache to arbiter
    mem_req_t imem_req;
    mem_rsp_t imem_rsp;
    mem_req_t dmem_req;
    mem_rsp_t dmem_rsp;

    l1_cache i_cache (
        .clk,
        .i_arst_n,
        .i_cpu_req (i_ireq),  // write held low by the core
        .o_cpu_rsp (o_irsp),
        .o_mem_req (imem_req),
        .i_mem_rsp (imem_rsp)
    );

    l1_cache d_cache (
        .clk,
        .i_arst_n,
        .i_cpu_req (i_dreq),
        .o_cpu_rsp (o_drsp),
        .o_mem_req (dmem_req),
        .i_mem_rsp (dmem_rsp)
    );

    mem_arbiter arbiter (
        .clk,
        .i_arst_n,
        .i_ireq    (imem_req),
        .o_irsp    (imem_rsp),
        .i_dreq    (dmem_req),
        .o_drsp    (dmem_rsp),
        .o_mem_req,
        .i_mem_rsp
    );

endmodule : mem_hier

`default_nettype wire

//--- sim/tb_mem_hier.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_hier import lc3b_types::*; ();

    logic        clk = 1'b0;
    logic        arst_n;
    cpu_req_t    ireq;
    cpu_rsp_t    irsp;
    cpu_req_t    dreq;
    cpu_rsp_t    drsp;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    logic [2:0]  mem_delay;
    int          mem_reads;
    int          mem_writes;
    logic [31:0] rand_state  = 32'd49590;  // stimulus and preload
    logic [31:0] delay_state = 32'd49590;  // memory latency only
    logic [7:0]  shadow [65536];           // byte image of main memory
    int          mismatches = 0;
    int          timeouts   = 0;

    mem_hier mem_hier_i (
        .clk       (clk),
        .i_arst_n  (arst_n),
        .i_ireq    (ireq),
        .o_irsp    (irsp),
        .i_dreq    (dreq),
        .o_drsp    (drsp),
        .o_mem_req (mem_req),
        .i_mem_rsp (mem_rsp)
    );

    tb_mem_model mem_model (
        .clk       (clk),
        .i_arst_n  (arst_n),
        .i_mem_req (mem_req),
        .i_delay   (mem_delay),
        .o_mem_rsp (mem_rsp),
        .o_reads   (mem_reads),
        .o_writes  (mem_writes)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            val   = {val[30:0], state[0]};
            state = lfsr_next(state);
        end
    endtask

    always @(negedge clk) begin
        logic [31:0] bits;
        take_bits(delay_state, 3, bits);
        mem_delay <= bits[2:0];
    end

    function automatic lc3b_word shadow_word(input lc3b_word addr);
        return {shadow[{addr[15:1], 1'b1}], shadow[{addr[15:1], 1'b0}]};
    endfunction

    function automatic lc3b_line shadow_line(input lc3b_word addr);
        lc3b_line line;
        for (int b = 0; b < 16; b++) begin
            line[8*b +: 8] = shadow[{addr[15:4], 4'h0} + b];
        end
        return line;
    endfunction

    task automatic check_word(input string name, input lc3b_word exp, input lc3b_word act);
        if (exp !== act) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_line(input string name, input lc3b_line exp, input lc3b_line act);
        if (exp !== act) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp !== act) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            mismatches++;
        end
    endtask

    // one core access, request held until resp, reads checked against the shadow
    task automatic access(input string name, input logic on_dport, input logic wr,
                          input lc3b_word addr, input lc3b_mem_wmask be, input lc3b_word wdata);
        cpu_req_t req;
        logic     done;
        lc3b_word rdata;
        req.read        = !wr;
        req.write       = wr;
        req.byte_enable = be;
        req.address     = addr;
        req.wdata       = wdata;
        done            = 1'b0;
        @(negedge clk);
        if (on_dport) begin
            dreq = req;
        end else begin
            ireq = req;
        end
        for (int c = 0; c < 200 && !done; c++) begin
            @(negedge clk);
            done  = on_dport ? drsp.resp : irsp.resp;
            rdata = on_dport ? drsp.rdata : irsp.rdata;
        end
        if (on_dport) begin
            dreq = '0;
        end else begin
            ireq = '0;
        end
        if (!done) begin
            $display("%s: response never arrived for address %h", name, addr);
            timeouts++;
        end else if (wr) begin
            if (be[0]) shadow[{addr[15:1], 1'b0}] = wdata[7:0];
            if (be[1]) shadow[{addr[15:1], 1'b1}] = wdata[15:8];
        end else begin
            check_word(name, shadow_word(addr), rdata);
        end
    endtask

    task automatic test_reset_quiet();
        int busy;
        busy = 0;
        for (int c = 0; c < 20; c++) begin
            @(negedge clk);
            if (irsp.resp || drsp.resp || mem_req.read || mem_req.write) busy++;
        end
        check_count("reset_quiet", 0, busy);
    endtask

    task automatic test_read_hit();
        int reads;
        access("read_miss", 1'b1, 1'b0, 16'h1234, 2'b11, '0);
        reads = mem_reads;
        access("read_hit", 1'b1, 1'b0, 16'h123a, 2'b11, '0);  // same line
        check_count("read_hit_mem_reads", reads, mem_reads);
    endtask

    task automatic test_byte_writes();
        logic [31:0] bits;
        int          writes;
        writes = mem_writes;
        for (int k = 1; k < 4; k++) begin
            take_bits(rand_state, 16, bits);
            access("byte_write", 1'b1, 1'b1, 16'h1232, k[1:0], bits[15:0]);
            access("byte_readback", 1'b1, 1'b0, 16'h1232, 2'b11, '0);
        end
        check_count("byte_write_mem_writes", writes, mem_writes);
    endtask

    // index 4, three different tags
    task automatic test_eviction();
        logic [31:0] bits;
        int          writes;
        take_bits(rand_state, 16, bits);
        access("evict_write", 1'b1, 1'b1, 16'h2046, 2'b11, bits[15:0]);
        writes = mem_writes;
        access("evict_read", 1'b1, 1'b0, 16'h2846, 2'b11, '0);
        check_count("dirty_evict_writes", writes + 1, mem_writes);
        check_line("dirty_evict_line", shadow_line(16'h2040), mem_model.peek_line(16'h2040));
        writes = mem_writes;
        access("clean_evict_read", 1'b1, 1'b0, 16'h3046, 2'b11, '0);
        check_count("clean_evict_writes", writes, mem_writes);
    endtask

    task automatic test_concurrent();
        int reads;
        reads = mem_reads;
        fork
            access("concurrent_fetch", 1'b0, 1'b0, 16'h8100, 2'b11, '0);
            access("concurrent_load", 1'b1, 1'b0, 16'h0250, 2'b11, '0);
        join
        check_count("concurrent_mem_reads", reads + 2, mem_reads);
    endtask

    // fetches stay above 0x8000 so the two caches never share a line
    task automatic test_random();
        logic [31:0]   bits;
        logic          on_dport;
        logic          wr;
        lc3b_mem_wmask be;
        lc3b_word      addr;
        for (int n = 0; n < 200; n++) begin
            take_bits(rand_state, 4, bits);
            on_dport = bits[3];
            wr       = bits[3] & bits[2];
            be       = (bits[1:0] == 2'b00) ? 2'b11 : bits[1:0];
            take_bits(rand_state, 16, bits);
            addr     = (bits[15:0] & 16'h30fe) | (on_dport ? 16'h0000 : 16'h8000);
            take_bits(rand_state, 16, bits);
            access("random", on_dport, wr, addr, be, bits[15:0]);
        end
    endtask

    initial begin
        logic [31:0] bits;
        arst_n    = 1'b0;
        ireq      = '0;
        dreq      = '0;
        mem_delay = '0;
        for (int l = 0; l < 4096; l++) begin
            for (int b = 0; b < 16; b++) begin
                take_bits(rand_state, 8, bits);
                shadow[l*16 + b] = bits[7:0];
            end
            mem_model.load_line(16'(l*16), shadow_line(16'(l*16)));
        end
        repeat (16) @(negedge clk);
        arst_n = 1'b1;

        test_reset_quiet();
        test_read_hit();
        test_byte_writes();
        test_eviction();
        test_concurrent();
        test_random();

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : tb_mem_hier

`default_nettype wire

//--- sim/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model import lc3b_types::*; (
    input  logic       clk,
    input  logic       i_arst_n,
    input  mem_req_t   i_mem_req,
    input  logic [2:0] i_delay,   // extra wait cycles for the next request
    output mem_rsp_t   o_mem_rsp,
    output int         o_reads,
    output int         o_writes
);

    lc3b_line    lines [4096];  // whole 64 KiB address space
    logic        busy;
    logic [2:0]  wait_cnt;
    logic [11:0] line_idx;

    assign line_idx = i_mem_req.address[15:LINE_OFFSET_BITS];

    always @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy      <= 1'b0;
            wait_cnt  <= '0;
            o_mem_rsp <= '0;
            o_reads   <= 0;
            o_writes  <= 0;
        end else begin
            o_mem_rsp.resp <= 1'b0;
            if (o_mem_rsp.resp) begin
                busy <= 1'b0;  // requester drops its request here
            end else if (!busy) begin
                if (i_mem_req.read || i_mem_req.write) begin
                    busy     <= 1'b1;
                    wait_cnt <= i_delay;
                end
            end else if (wait_cnt != 3'd0) begin
                wait_cnt <= wait_cnt - 3'd1;
            end else begin
                o_mem_rsp.resp <= 1'b1;
                if (i_mem_req.write) begin
                    lines[line_idx] <= i_mem_req.wdata;
                    o_writes        <= o_writes + 1;
                end else begin
                    o_mem_rsp.rdata <= lines[line_idx];
                    o_reads         <= o_reads + 1;
                end
            end
        end
    end

    // backdoor access by line address
    task automatic load_line(input lc3b_word addr, input lc3b_line data);
        lines[addr[15:LINE_OFFSET_BITS]] = data;
    endtask

    function automatic lc3b_line peek_line(input lc3b_word addr);
        return lines[addr[15:LINE_OFFSET_BITS]];
    endfunction

endmodule : tb_mem_model

`default_nettype wire
